// File: hw/isaDecodePkg.sv
package isaDecodePkg;

  localparam int instrW = 32;
  localparam int aluCtrlW = 5;
  localparam int shiftAmtW = 5;

  typedef enum logic {
    isaRv,
    isaArm
  } isaE;

  typedef enum logic [aluCtrlW-1:0] {
    aluAdd = 5'd0,
    aluSub = 5'd1,
    aluAnd = 5'd2,
    aluOr  = 5'd3,
    aluXor = 5'd4,
    aluSlt = 5'd5,
    aluLui = 5'd6,
    aluSll = 5'd8,
    aluSrl = 5'd9,
    aluSra = 5'd10,
    aluBic = 5'd16, // ARM only from here on
    aluAdc = 5'd18,
    aluSbc = 5'd19,
    aluRsb = 5'd20,
    aluRsc = 5'd22,
    aluMvn = 5'd23
  } aluCtrlE;

  // ARM mov reuses the lui pass-through path of the ALU
  localparam aluCtrlE aluMov = aluLui;

  typedef enum logic [3:0] {
    condEq = 4'd0,
    condNe = 4'd1,
    condCs = 4'd2,
    condCc = 4'd3,
    condGe = 4'd10,
    condLt = 4'd11,
    condAl = 4'd14
  } condE;

  typedef enum logic [6:0] {
    opLoad  = 7'b0000011,
    opStore = 7'b0100011,
    opRtype = 7'b0110011,
    opBtype = 7'b1100011,
    opItype = 7'b0010011,
    opJal   = 7'b1101111,
    opJalr  = 7'b1100111,
    opLui   = 7'b0110111,
    opAuipc = 7'b0010111
  } rvOpE;

  typedef enum logic [1:0] {
    ldmIdle,
    ldmStep1
  } ldmStepE;

endpackage

// File: hw/decodeIf.sv
interface decodeIf import isaDecodePkg::*; ();
  logic regWrite;
  logic memWrite;
  logic [1:0] memSize;
  logic memSigned;
  aluCtrlE aluControl;
  logic [1:0] branch;
  logic [1:0] aluSrc;
  logic [2:0] immSrc;
  condE cond;
  logic [1:0] resultSrc;
  logic pcSrc; // ARM only
  logic [1:0] flagWrite; // ARM only
  logic [1:0] regSrc; // ARM only
  logic [shiftAmtW-1:0] shiftAmt; // ARM only
  logic [2:0] shiftType; // ARM only
  logic stallF; // high for LDM micro-ops
  logic legal;

  modport producer(output regWrite, memWrite, memSize, memSigned, aluControl, branch, aluSrc,
                   immSrc, cond, resultSrc, pcSrc, flagWrite, regSrc, shiftAmt, shiftType,
                   stallF, legal);
  modport consumer(input regWrite, memWrite, memSize, memSigned, aluControl, branch, aluSrc,
                   immSrc, cond, resultSrc, pcSrc, flagWrite, regSrc, shiftAmt, shiftType,
                   stallF, legal);
endinterface

// File: hw/rvDecoder.sv
module rvDecoder import isaDecodePkg::*; (
  input logic [instrW-1:0] instr,
  decodeIf.producer dec
);
  rvOpE op;
  logic [2:0] funct3;
  logic funct7b5;
  logic rtypeSub;
  logic mainOk;
  logic brOk;
  logic [1:0] aluOp;
  logic [15:0] controls;

  assign op = rvOpE'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7b5 = instr[30];
  assign rtypeSub = funct7b5 & instr[5]; // only R-type subtracts

  // regWrite_immSrc_aluSrc_memWrite_memSigned_memSize_resultSrc_branch_aluOp
  always_comb begin
    mainOk = 1'b1;
    case (op)
      opLoad: begin
        case (funct3)
          3'b000: controls = 16'b1_000_01_0_1_00_01_00_00; // lb
          3'b001: controls = 16'b1_000_01_0_1_01_01_00_00; // lh
          3'b010: controls = 16'b1_000_01_0_0_10_01_00_00; // lw
          3'b100: controls = 16'b1_000_01_0_0_00_01_00_00; // lbu
          3'b101: controls = 16'b1_000_01_0_0_01_01_00_00; // lhu
          default: begin
            controls = '0;
            mainOk = 1'b0;
          end
        endcase
      end
      opStore: begin
        case (funct3)
          3'b000: controls = 16'b0_001_01_1_0_00_00_00_00; // sb
          3'b001: controls = 16'b0_001_01_1_0_01_00_00_00; // sh
          3'b010: controls = 16'b0_001_01_1_0_10_00_00_00; // sw
          default: begin
            controls = '0;
            mainOk = 1'b0;
          end
        endcase
      end
      opRtype: controls = 16'b1_000_00_0_0_00_00_00_10;
      opBtype: controls = 16'b0_010_00_0_0_00_00_01_01;
      opItype: controls = 16'b1_000_01_0_0_00_00_00_10;
      opJal:   controls = 16'b1_011_10_0_0_00_10_01_00;
      opJalr:  controls = 16'b1_000_01_0_0_00_10_10_00;
      opLui:   controls = 16'b1_111_01_0_0_00_00_00_11;
      opAuipc: controls = 16'b1_111_11_0_0_00_00_00_00;
      default: begin
        controls = '0; // unknown opcode
        mainOk = 1'b0;
      end
    endcase
  end

  assign {dec.regWrite, dec.immSrc, dec.aluSrc, dec.memWrite, dec.memSigned, dec.memSize,
          dec.resultSrc, dec.branch, aluOp} = controls;

  always_comb begin
    brOk = 1'b1;
    dec.cond = condAl; // non-branches always execute
    case (aluOp)
      2'b00: dec.aluControl = aluAdd; // address calc
      2'b11: dec.aluControl = aluLui;
      2'b01: begin
        dec.aluControl = aluSub; // compare for branch
        case (funct3)
          3'b000: dec.cond = condEq;
          3'b001: dec.cond = condNe;
          3'b100: dec.cond = condLt;
          3'b101: dec.cond = condGe;
          3'b110: dec.cond = condCc; // bltu
          3'b111: dec.cond = condCs; // bgeu
          default: brOk = 1'b0;
        endcase
      end
      default: begin
        case (funct3)
          3'b000: dec.aluControl = rtypeSub ? aluSub : aluAdd;
          3'b001: dec.aluControl = aluSll;
          3'b010: dec.aluControl = aluSlt;
          3'b011: dec.aluControl = aluSlt; // sltu shares the slt path
          3'b100: dec.aluControl = aluXor;
          3'b101: dec.aluControl = funct7b5 ? aluSra : aluSrl;
          3'b110: dec.aluControl = aluOr;
          default: dec.aluControl = aluAnd;
        endcase
      end
    endcase
  end

  assign dec.legal = mainOk & brOk;
  assign dec.pcSrc = 1'b0;
  assign dec.flagWrite = 2'b00;
  assign dec.regSrc = 2'b00;
  assign dec.shiftAmt = '0;
  assign dec.shiftType = 3'b000;
  assign dec.stallF = 1'b0;

endmodule

// File: hw/armDecoder.sv
module armDecoder import isaDecodePkg::*; (
  input logic [instrW-1:0] instr,
  input ldmStepE ldmStep,
  decodeIf.producer dec
);
  logic [2:0] op;
  logic [5:0] funct;
  logic [3:0] rd;
  logic [7:0] shift;
  logic [12:0] controls;
  logic [1:0] regSrc;
  logic [1:0] immSrc;
  logic [1:0] dpShift;
  logic aluSrc, memToReg, regW, memW, branch, aluOp, stallF;
  aluCtrlE aluCtl;

  assign op = instr[27:25];
  assign funct = instr[25:20]; // I bit, cmd, S or L bit
  assign rd = instr[15:12];
  assign shift = instr[11:4];

  // regSrc_immSrc_aluSrc_memToReg_regW_memW_branch_aluOp_dpShift_stallF
  always_comb begin
    dec.legal = 1'b1;
    if (ldmStep == ldmStep1) begin
      controls = 13'b00_11_1_0_0_0_0_0_00_1; // second LDM micro-op, word may be gone
    end else begin
      casez (op)
        3'b00?: begin
          if (funct[5]) // immediate operand
            controls = (funct[4:3] == 2'b10) ? 13'b00_00_1_0_0_0_0_1_10_0
                                             : 13'b00_00_1_0_1_0_0_1_10_0;
          else // register operand
            controls = (funct[4:3] == 2'b10) ? 13'b00_00_0_0_0_0_0_1_01_0
                                             : 13'b00_00_0_0_1_0_0_1_01_0;
        end
        3'b01?: controls = funct[0] ? 13'b00_01_1_1_1_0_0_0_00_0  // ldr
                                    : 13'b10_01_1_1_0_1_0_0_00_0; // str
        3'b101: controls = 13'b01_10_1_0_0_0_1_0_00_0; // b
        3'b100: controls = 13'b00_00_0_0_0_0_0_0_00_1; // first LDM micro-op
        default: begin
          controls = '0;
          dec.legal = 1'b0;
        end
      endcase
    end
  end

  assign {regSrc, immSrc, aluSrc, memToReg, regW, memW, branch, aluOp, dpShift, stallF} =
    controls;

  always_comb begin
    case (dpShift)
      2'b01: begin
        dec.shiftType = {1'b1, shift[2:1]}; // register operand shift
        dec.shiftAmt = shift[7:3];
      end
      2'b10: begin
        dec.shiftType = 3'b111; // immediate rotate
        dec.shiftAmt = {shift[7:4], 1'b0};
      end
      default: begin
        dec.shiftType = 3'b100;
        dec.shiftAmt = '0;
      end
    endcase
  end

  always_comb begin
    if (aluOp) begin
      case (funct[4:1])
        4'b0000: aluCtl = aluAnd;
        4'b0001: aluCtl = aluXor;
        4'b0010: aluCtl = aluSub;
        4'b0011: aluCtl = aluRsb;
        4'b0100: aluCtl = aluAdd;
        4'b0101: aluCtl = aluAdc;
        4'b0110: aluCtl = aluSbc;
        4'b0111: aluCtl = aluRsc;
        4'b1000: aluCtl = aluAnd; // tst
        4'b1001: aluCtl = aluXor; // teq
        4'b1010: aluCtl = aluSub; // cmp
        4'b1011: aluCtl = aluAdd; // cmn
        4'b1100: aluCtl = aluOr;
        4'b1101: aluCtl = aluMov;
        4'b1110: aluCtl = aluBic;
        default: aluCtl = aluMvn;
      endcase
      dec.flagWrite[1] = funct[0]; // N and Z on any S
      dec.flagWrite[0] = funct[0] & (aluCtl == aluAdd || aluCtl == aluSub);
    end else begin
      aluCtl = aluAdd; // address or target calc
      dec.flagWrite = 2'b00;
    end
  end

  assign dec.aluControl = aluCtl;
  assign dec.regWrite = regW;
  assign dec.memWrite = memW;
  assign dec.memSize = (memToReg | memW) ? 2'b10 : 2'b00; // word transfers only
  assign dec.memSigned = 1'b0;
  assign dec.branch = {branch, 1'b0};
  assign dec.aluSrc = {1'b0, aluSrc};
  assign dec.immSrc = {1'b0, immSrc};
  assign dec.cond = condE'(instr[31:28]);
  assign dec.resultSrc = {1'b0, memToReg};
  assign dec.pcSrc = (rd == 4'hf) & regW; // write to r15
  assign dec.regSrc = regSrc;
  assign dec.stallF = stallF;

endmodule

// File: hw/decodeSelect.sv
module decodeSelect import isaDecodePkg::*; (
  decodeIf.consumer rv,
  decodeIf.consumer arm,
  input isaE mode,
  input logic wasNotFlushed,
  decodeIf.producer sel
);
  logic useArm;
  logic bad;

  assign useArm = (mode == isaArm);
  assign bad = wasNotFlushed & ~rv.legal & ~arm.legal; // neither ISA accepts it

  // shared fields
  assign sel.regWrite = ~bad & (useArm ? arm.regWrite : rv.regWrite);
  assign sel.memWrite = ~bad & (useArm ? arm.memWrite : rv.memWrite);
  assign sel.memSize = bad ? 2'b00 : (useArm ? arm.memSize : rv.memSize);
  assign sel.memSigned = ~bad & (useArm ? arm.memSigned : rv.memSigned);
  assign sel.aluControl = bad ? aluAdd : (useArm ? arm.aluControl : rv.aluControl);
  assign sel.cond = bad ? condAl : (useArm ? arm.cond : rv.cond);

  // RISC-V only bits cleared in ARM mode
  assign sel.branch = bad ? 2'b00 : (useArm ? {arm.branch[1], 1'b0} : rv.branch);
  assign sel.aluSrc = bad ? 2'b00 : (useArm ? {1'b0, arm.aluSrc[0]} : rv.aluSrc);
  assign sel.immSrc = bad ? 3'b000 : (useArm ? {1'b0, arm.immSrc[1:0]} : rv.immSrc);
  assign sel.resultSrc = bad ? 2'b00 : (useArm ? {1'b0, arm.resultSrc[0]} : rv.resultSrc);

  // ARM only fields
  assign sel.pcSrc = ~bad & useArm & arm.pcSrc;
  assign sel.flagWrite = (~bad & useArm) ? arm.flagWrite : 2'b00;
  assign sel.regSrc = (~bad & useArm) ? arm.regSrc : 2'b00;
  assign sel.shiftAmt = (~bad & useArm) ? arm.shiftAmt : '0;
  assign sel.shiftType = (~bad & useArm) ? arm.shiftType : 3'b000;
  assign sel.stallF = ~bad & useArm & arm.stallF;

  assign sel.legal = ~bad;

endmodule

// File: hw/decodeControl.sv
module decodeControl import isaDecodePkg::*; (
  input logic clk,
  input logic rst,
  input logic instrValid,
  output logic instrReady,
  input logic wasNotFlushed,
  input logic rvLegal,
  input logic armLegal,
  input logic isLdm,
  decodeIf.consumer sel,
  output isaE mode,
  output ldmStepE ldmStep,
  output logic decValid,
  input logic decReady,
  decodeIf.producer out,
  output logic isArm
);
  isaE modeQ;
  logic canLoad;
  logic accept;
  logic stepLoad;

  assign canLoad = ~decValid | decReady; // slot empty or leaving
  assign instrReady = canLoad & (ldmStep == ldmIdle);
  assign accept = instrValid & instrReady;
  assign stepLoad = canLoad & (ldmStep == ldmStep1); // micro-op 0 leaving

  // next mode, seen by the select mux in the same cycle
  always_comb begin
    mode = modeQ;
    if (accept && wasNotFlushed) begin
      if (rvLegal && !armLegal)
        mode = isaRv;
      else if (armLegal && !rvLegal)
        mode = isaArm;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      modeQ <= isaRv;
      ldmStep <= ldmIdle;
      decValid <= 1'b0;
    end else if (accept) begin
      modeQ <= mode;
      decValid <= 1'b1;
      if (mode == isaArm && isLdm)
        ldmStep <= ldmStep1;
    end else if (stepLoad) begin
      decValid <= 1'b1;
      ldmStep <= ldmIdle;
    end else if (decReady) begin
      decValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept || stepLoad) begin
      out.regWrite <= sel.regWrite;
      out.memWrite <= sel.memWrite;
      out.memSize <= sel.memSize;
      out.memSigned <= sel.memSigned;
      out.aluControl <= sel.aluControl;
      out.branch <= sel.branch;
      out.aluSrc <= sel.aluSrc;
      out.immSrc <= sel.immSrc;
      out.cond <= stepLoad ? out.cond : sel.cond; // micro-op 1 keeps the LDM condition
      out.resultSrc <= sel.resultSrc;
      out.pcSrc <= sel.pcSrc;
      out.flagWrite <= sel.flagWrite;
      out.regSrc <= sel.regSrc;
      out.shiftAmt <= sel.shiftAmt;
      out.shiftType <= sel.shiftType;
      out.stallF <= sel.stallF;
      out.legal <= sel.legal;
      isArm <= (mode == isaArm);
    end
  end

  // a stalled item must not change under the consumer
  assert property (@(posedge clk) disable iff (rst)
    decValid && !decReady |=> decValid && $stable({out.regWrite, out.memWrite, out.memSize,
      out.memSigned, out.aluControl, out.branch, out.aluSrc, out.immSrc, out.cond,
      out.resultSrc, out.pcSrc, out.flagWrite, out.regSrc, out.shiftAmt, out.shiftType,
      out.stallF, out.legal, isArm}));

  // micro-op 0 stays held and no new word comes in until micro-op 1 loads
  assert property (@(posedge clk) disable iff (rst)
    ldmStep == ldmStep1 |-> !instrReady && decValid);

endmodule

// File: hw/decodeStage.sv
module decodeStage import isaDecodePkg::*; (
  input logic clk,
  input logic rst,
  input logic instrValid,
  output logic instrReady,
  input logic [instrW-1:0] instr,
  input logic wasNotFlushed,
  output logic decValid,
  input logic decReady,
  output logic regWrite,
  output logic memWrite,
  output logic [1:0] memSize,
  output logic memSigned,
  output aluCtrlE aluControl,
  output logic [1:0] branch,
  output logic [1:0] aluSrc,
  output logic [2:0] immSrc,
  output condE cond,
  output logic [1:0] resultSrc,
  output logic pcSrc,
  output logic [1:0] flagWrite,
  output logic [1:0] regSrc,
  output logic [shiftAmtW-1:0] shiftAmt,
  output logic [2:0] shiftType,
  output logic stallF,
  output logic isArm,
  output logic illegal
);
  decodeIf rvBus();
  decodeIf armBus();
  decodeIf selBus();
  decodeIf outBus();
  isaE mode;
  ldmStepE ldmStep;

  rvDecoder rvDec_i (.instr(instr), .dec(rvBus));

  armDecoder armDec_i (.instr(instr), .ldmStep(ldmStep), .dec(armBus));

  decodeSelect sel_i (.rv(rvBus), .arm(armBus), .mode(mode), .wasNotFlushed(wasNotFlushed),
                      .sel(selBus));

  decodeControl ctrl_i (
    .clk(clk),
    .rst(rst),
    .instrValid(instrValid),
    .instrReady(instrReady),
    .wasNotFlushed(wasNotFlushed),
    .rvLegal(rvBus.legal),
    .armLegal(armBus.legal),
    .isLdm(armBus.stallF), // only LDM stalls fetch
    .sel(selBus),
    .mode(mode),
    .ldmStep(ldmStep),
    .decValid(decValid),
    .decReady(decReady),
    .out(outBus),
    .isArm(isArm)
  );

  assign regWrite = outBus.regWrite;
  assign memWrite = outBus.memWrite;
  assign memSize = outBus.memSize;
  assign memSigned = outBus.memSigned;
  assign aluControl = outBus.aluControl;
  assign branch = outBus.branch;
  assign aluSrc = outBus.aluSrc;
  assign immSrc = outBus.immSrc;
  assign cond = outBus.cond;
  assign resultSrc = outBus.resultSrc;
  assign pcSrc = outBus.pcSrc;
  assign flagWrite = outBus.flagWrite;
  assign regSrc = outBus.regSrc;
  assign shiftAmt = outBus.shiftAmt;
  assign shiftType = outBus.shiftType;
  assign stallF = outBus.stallF;
  assign illegal = ~outBus.legal;

endmodule

// File: tb/decodeChecker.sv
module decodeChecker (
  input logic clk,
  input logic rst,
  input logic decValid,
  input logic decReady,
  input logic regWrite,
  input logic memWrite,
  input logic [1:0] memSize,
  input logic memSigned,
  input logic [4:0] aluControl,
  input logic [1:0] branch,
  input logic [1:0] aluSrc,
  input logic [2:0] immSrc,
  input logic [3:0] cond,
  input logic [1:0] resultSrc,
  input logic pcSrc,
  input logic [1:0] flagWrite,
  input logic [1:0] regSrc,
  input logic [4:0] shiftAmt,
  input logic [2:0] shiftType,
  input logic stallF,
  input logic isArm,
  input logic illegal
);
  logic [23:0] expQ[$];
  logic [23:0] got;
  logic [23:0] want;
  logic [38:0] snap;
  logic [38:0] heldSnap;
  logic stalled = 1'b0;
  int itemNo = 0;
  int mismatches = 0;
  int stallChanges = 0;
  int extraItems = 0;

  // isArm illegal regWrite memWrite memSize aluControl cond flagWrite pcSrc shiftAmt stallF
  assign got = {isArm, illegal, regWrite, memWrite, memSize, aluControl, cond, flagWrite,
                pcSrc, shiftAmt, stallF};
  assign snap = {regWrite, memWrite, memSize, memSigned, aluControl, branch, aluSrc, immSrc,
                 cond, resultSrc, pcSrc, flagWrite, regSrc, shiftAmt, shiftType, stallF,
                 isArm, illegal}; // every output field

  task automatic pushExpected(input logic [23:0] item);
    expQ.push_back(item);
  endtask

  function automatic int pending();
    return expQ.size();
  endfunction

  // mid-cycle sample, a transfer happens on the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      stalled = 1'b0;
    end else begin
      if (stalled && (!decValid || snap !== heldSnap)) begin
        stallChanges++;
        $display("Mismatch at %0t: outputs changed while decValid high and decReady low",
                 $time);
      end
      if (decValid && decReady) begin
        if (expQ.size() == 0) begin
          extraItems++;
          $display("unexpected output item at %0t, no expected item was left", $time);
        end else begin
          want = expQ.pop_front();
          if (got !== want) begin
            mismatches++;
            $display("Mismatch at %0t: item %0d expected %h got %h", $time, itemNo, want, got);
          end
        end
        itemNo++;
      end
      stalled = decValid && !decReady;
      heldSnap = snap;
    end
  end

endmodule

// File: tb/decodeStageTb.sv
module decodeStageTb import isaDecodePkg::*; ();
  logic clk = 1'b0;
  logic rst;
  logic instrValid;
  logic instrReady;
  logic [instrW-1:0] instr;
  logic wasNotFlushed;
  logic decValid;
  logic decReady;
  logic regWrite;
  logic memWrite;
  logic [1:0] memSize;
  logic memSigned;
  aluCtrlE aluControl;
  logic [1:0] branch;
  logic [1:0] aluSrc;
  logic [2:0] immSrc;
  condE cond;
  logic [1:0] resultSrc;
  logic pcSrc;
  logic [1:0] flagWrite;
  logic [1:0] regSrc;
  logic [shiftAmtW-1:0] shiftAmt;
  logic [2:0] shiftType;
  logic stallF;
  logic isArm;
  logic illegal;
  integer seed = 24;

  logic [31:0] tblInstr[$];
  logic tblNotFlushed[$];
  int tblItems[$];
  logic [23:0] tblExp[$];

  int entryIdx;
  int itemIdx;
  int waitCycles;
  int missing;
  int errors;
  logic accepted;
  logic timedOut;

  always #5 clk = ~clk;

  decodeStage dut_i (.*);

  decodeChecker chk_i (.*);

  // flags are {isArm, illegal, regWrite, memWrite, pcSrc, stallF}
  task automatic addEntry(input logic [31:0] word, input logic notFlushed, input int items,
                          input logic [5:0] flags, input logic [1:0] sizeW, input aluCtrlE alu,
                          input condE cc, input logic [1:0] flagW, input logic [4:0] shAmt);
    tblInstr.push_back(word);
    tblNotFlushed.push_back(notFlushed);
    tblItems.push_back(items);
    tblExp.push_back({flags[5:2], sizeW, alu, cc, flagW, flags[1], shAmt, flags[0]});
  endtask

  task automatic loadTable();
    addEntry(32'h002081B3, 1'b1, 1, 6'b001000, 2'b00, aluAdd, condAl, 2'b00, 5'd0); // add
    addEntry(32'h402081B3, 1'b1, 1, 6'b001000, 2'b00, aluSub, condAl, 2'b00, 5'd0); // sub
    addEntry(32'h4020D1B3, 1'b1, 1, 6'b001000, 2'b00, aluSra, condAl, 2'b00, 5'd0); // sra
    addEntry(32'h0080A283, 1'b1, 1, 6'b001000, 2'b10, aluAdd, condAl, 2'b00, 5'd0); // lw
    addEntry(32'h00508223, 1'b1, 1, 6'b000100, 2'b00, aluAdd, condAl, 2'b00, 5'd0); // sb
    addEntry(32'h00208463, 1'b1, 1, 6'b000000, 2'b00, aluSub, condEq, 2'b00, 5'd0); // beq
    addEntry(32'h0020C463, 1'b1, 1, 6'b000000, 2'b00, aluSub, condLt, 2'b00, 5'd0); // blt
    addEntry(32'h123453B7, 1'b1, 1, 6'b001000, 2'b00, aluLui, condAl, 2'b00, 5'd0); // lui
    addEntry(32'hE0021004, 1'b1, 1, 6'b101000, 2'b00, aluAnd, condAl, 2'b00, 5'd0); // and
    addEntry(32'hE0121004, 1'b1, 1, 6'b101000, 2'b00, aluAnd, condAl, 2'b10, 5'd0); // ands
    addEntry(32'hE2421105, 1'b1, 1, 6'b101000, 2'b00, aluSub, condAl, 2'b00, 5'd2); // sub #imm
    addEntry(32'hE2521105, 1'b1, 1, 6'b101000, 2'b00, aluSub, condAl, 2'b11, 5'd2); // subs
    addEntry(32'hE0621184, 1'b1, 1, 6'b101000, 2'b00, aluRsb, condAl, 2'b00, 5'd3); // rsb lsl 3
    addEntry(32'hE0721184, 1'b1, 1, 6'b101000, 2'b00, aluRsb, condAl, 2'b10, 5'd3); // rsbs
    addEntry(32'hE1A01004, 1'b1, 1, 6'b101000, 2'b00, aluMov, condAl, 2'b00, 5'd0); // mov
    addEntry(32'hE1B01004, 1'b1, 1, 6'b101000, 2'b00, aluMov, condAl, 2'b10, 5'd0); // movs
    addEntry(32'hE1A0F004, 1'b1, 1, 6'b101010, 2'b00, aluMov, condAl, 2'b00, 5'd0); // mov pc
    addEntry(32'hE5921004, 1'b1, 1, 6'b101000, 2'b10, aluAdd, condAl, 2'b00, 5'd0); // ldr
    addEntry(32'hE5821004, 1'b1, 1, 6'b100100, 2'b10, aluAdd, condAl, 2'b00, 5'd0); // str
    // legal in both, mode stays arm
    addEntry(32'hE0821033, 1'b1, 1, 6'b101000, 2'b00, aluAdd, condAl, 2'b00, 5'd0);
    // flushed addi, stays arm and decodes as an undefined arm word
    addEntry(32'h0E000093, 1'b0, 1, 6'b100000, 2'b00, aluAdd, condEq, 2'b00, 5'd0);
    addEntry(32'h0E000093, 1'b1, 1, 6'b001000, 2'b00, aluAdd, condAl, 2'b00, 5'd0); // to rv
    addEntry(32'hE0821033, 1'b1, 1, 6'b001000, 2'b00, aluSll, condAl, 2'b00, 5'd0); // stays rv
    addEntry(32'hEE000010, 1'b1, 1, 6'b010000, 2'b00, aluAdd, condAl, 2'b00, 5'd0); // illegal
    addEntry(32'hE8900006, 1'b1, 2, 6'b100001, 2'b00, aluAdd, condAl, 2'b00, 5'd0); // ldm
    addEntry(32'hE0121004, 1'b1, 1, 6'b101000, 2'b00, aluAnd, condAl, 2'b10, 5'd0); // ands
    addEntry(32'h18900006, 1'b1, 2, 6'b100001, 2'b00, aluAdd, condNe, 2'b00, 5'd0); // ldmne
    addEntry(32'h0E000093, 1'b1, 1, 6'b001000, 2'b00, aluAdd, condAl, 2'b00, 5'd0); // addi
  endtask

  // random back-pressure on the output side
  initial begin
    decReady = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      decReady = (($random(seed) & 1) != 0);
    end
  end

  initial begin
    rst = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    wasNotFlushed = 1'b1;
    timedOut = 1'b0;
    loadTable();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    entryIdx = 0;
    while (entryIdx < tblInstr.size() && !timedOut) begin
      instr = tblInstr[entryIdx];
      wasNotFlushed = tblNotFlushed[entryIdx];
      instrValid = 1'b1;
      // both LDM micro-ops carry the same checked fields
      for (itemIdx = 0; itemIdx < tblItems[entryIdx]; itemIdx++)
        chk_i.pushExpected(tblExp[entryIdx]);
      accepted = 1'b0;
      waitCycles = 0;
      while (!accepted && waitCycles < 100) begin
        @(negedge clk);
        accepted = instrReady; // taken on the coming edge
        @(posedge clk);
        waitCycles++;
      end
      #1;
      if (!accepted) begin
        timedOut = 1'b1;
        $display("timeout: entry %0d was not accepted within 100 cycles", entryIdx);
      end
      entryIdx++;
    end
    instrValid = 1'b0;
    waitCycles = 0;
    while (!timedOut && chk_i.pending() != 0 && waitCycles < 200) begin
      @(posedge clk);
      waitCycles++;
    end
    repeat (4) @(posedge clk); // catch stray extra items
    missing = chk_i.pending();
    if (missing != 0)
      $display("%0d expected output items never arrived", missing);
    errors = chk_i.mismatches + chk_i.stallChanges + chk_i.extraItems + missing +
             (timedOut ? 1 : 0);
    $display("errors: %0d mismatch, %0d stall change, %0d extra, %0d missing, %0d timeout",
             chk_i.mismatches, chk_i.stallChanges, chk_i.extraItems, missing, timedOut ? 1 : 0);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: project.f
hw/isaDecodePkg.sv
hw/decodeIf.sv
hw/rvDecoder.sv
hw/armDecoder.sv
hw/decodeSelect.sv
hw/decodeControl.sv
hw/decodeStage.sv
tb/decodeChecker.sv
tb/decodeStageTb.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f project.f --top-module decodeStageTb -Mdir obj_dir \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/VdecodeStageTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' sim.log; then
  exit 0
fi
exit 1
